// ==== verification/dispatch_vectors.txt ====
// Columns are unit, op, pc, imm, rd, rs1, rs2, then the expected rd, rs1 and rs2 copies.
// All fields are hex. Units are 0 ALU, 1 BRU, 2 LSU and 3 MUL.
0 0 80001000 0                05 01 02 1 0 0
3 0 80001004 0                06 05 05 1 1 1
2 3 80001008 8                05 06 00 2 1 0
1 2 8000100c fffffffffffffff0 00 05 06 0 2 1
0 1 80001010 0                05 05 07 3 2 0
2 a 80001014 10               00 02 05 0 0 3
3 4 80001018 0                07 05 06 1 3 1
0 4 8000101c 0                05 07 05 0 1 3
1 0 80001020 40               01 00 00 1 0 0
0 0 80001024 0                05 01 05 1 1 0
2 2 80001028 0                08 05 00 1 1 0
3 1 8000102c 0                09 08 05 1 1 1
1 3 80001030 ffffffffffffffe0 00 09 00 0 1 0
0 2 80001034 0                0a 09 06 1 1 1
0 3 80001038 0                06 0a 08 2 1 1
3 6 8000103c 0                0b 06 07 1 2 1
2 9 80001040 18               00 0b 06 0 1 2
0 c 80001044 7ff              0c 0b 00 1 1 0

// ==== filelist.f ====
+incdir+src
src/decode_pkg.sv
src/rename_pkg.sv
src/instr_queue.sv
src/rename_table.sv
src/dispatch.sv
src/issue_queue.sv
src/issue_select.sv
src/dispatch_top.sv
verification/dispatch_assert.sv
verification/dispatch_tb.sv

// ==== verification/dispatch_tb.sv ====
// ##############################
// Dispatch testbench
// Replays the instruction vectors
// and checks the reorder and
// issue streams of the top level.
// ##############################

`timescale 1ns/10ps
`include "dispatch_consts.svh"

module dispatch_tb
	import decode_pkg::*;
	import rename_pkg::*;
();

	localparam int FIELDS = 10;         // Hex words on one vector line.
	localparam int MAX_VECS = 64;
	localparam int RESET_CYCLES = 4;
	localparam int CYCLES_PER_VEC = 40;

	typedef struct packed {
		decoded_instr_t instr;
		reg_tag_t       rd_tag;
		reg_tag_t       rs1_tag;
		reg_tag_t       rs2_tag;
	} vector_t;

	logic clk;
	logic reset;
	logic in_push;
	decoded_instr_t in_instr;
	logic in_full;
	logic rob_push;
	rob_entry_t rob_entry;
	logic rob_full;
	commit_t commit;
	logic issue_valid;
	issue_entry_t issue_entry;
	logic issue_ready;

	logic [63:0] vec_mem [FIELDS*MAX_VECS];
	vector_t vecs [MAX_VECS];
	int prev_write [MAX_VECS];      // Write whose copy must retire first, or -1.
	bit released [MAX_VECS];
	int next_idx [`NUM_UNITS];      // Next expected vector on the issue bus per unit.
	int num_vecs = 0;
	int rob_count = 0;
	int issue_count = 0;
	int checks = 0;
	int errors = 0;
	bit loaded = 1'b0;
	bit hold = 1'b0;                // Lifts all back-pressure while a stall is observed.
	logic [31:0] rng;

	dispatch_top dut (
		.clk         (clk),
		.reset       (reset),
		.in_push     (in_push),
		.in_instr    (in_instr),
		.in_full     (in_full),
		.rob_push    (rob_push),
		.rob_entry   (rob_entry),
		.rob_full    (rob_full),
		.commit      (commit),
		.issue_valid (issue_valid),
		.issue_entry (issue_entry),
		.issue_ready (issue_ready)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic int find_unit(input logic [1:0] u, input int from);
		for (int i = from; i < num_vecs; i++) begin
			if (vecs[i].instr.unit == u) return i;
		end
		return -1;
	endfunction

	task automatic check(input string name, input int idx, input logic [63:0] exp,
			input logic [63:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("Mismatch %s, vector %0d: expected %h, actual %h", name, idx, exp, act);
		end
	endtask

	task automatic report_error(input string what);
		errors++;
		$display("Error: %s", what);
	endtask

	task automatic load_vectors();
		int b;
		int seen;
		// Unloaded words keep an all-ones upper half, which no unit field has.
		for (int a = 0; a < FIELDS * MAX_VECS; a++) vec_mem[a] = {32'hffff_ffff, 32'(a)};
		$readmemh("verification/dispatch_vectors.txt", vec_mem);
		while (num_vecs < MAX_VECS && vec_mem[num_vecs * FIELDS][63:32] != 32'hffff_ffff) begin
			b = num_vecs * FIELDS;
			vecs[num_vecs].instr = {vec_mem[b][1:0], vec_mem[b+1][3:0], vec_mem[b+2],
				vec_mem[b+3], vec_mem[b+4][4:0], vec_mem[b+5][4:0], vec_mem[b+6][4:0]};
			vecs[num_vecs].rd_tag = {vec_mem[b+4][4:0], vec_mem[b+7][1:0]};
			vecs[num_vecs].rs1_tag = {vec_mem[b+5][4:0], vec_mem[b+8][1:0]};
			vecs[num_vecs].rs2_tag = {vec_mem[b+6][4:0], vec_mem[b+9][1:0]};
			num_vecs++;
		end
		// With no commits a write waits for the copy of the write RENAME_COPIES back.
		for (int v = 0; v < num_vecs; v++) begin
			prev_write[v] = -1;
			released[v] = 1'b0;
			seen = 0;
			for (int j = v - 1; j >= 0 && vecs[v].instr.rd != 5'd0; j--) begin
				if (vecs[j].instr.rd == vecs[v].instr.rd) seen++;
				if (seen == `RENAME_COPIES && prev_write[v] < 0) prev_write[v] = j;
			end
		end
		for (int u = 0; u < `NUM_UNITS; u++) next_idx[u] = find_unit(2'(u), 0);
	endtask

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		in_push = 1'b0;
		in_instr = '0;
		rob_full = 1'b0;
		commit = '0;
		issue_ready = 1'b0;
		load_vectors();
		if (num_vecs == 0) report_error("no vectors were read from the vector file");
		loaded = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 reset = 1'b0;
		@(negedge clk);
		check("reset in_full", -1, 64'd0, 64'(in_full));
		check("reset rob_push", -1, 64'd0, 64'(rob_push));
		check("reset issue_valid", -1, 64'd0, 64'(issue_valid));
		for (int v = 0; v < num_vecs; ) begin
			@(posedge clk);
			#1;
			in_push = ~in_full;
			if (!in_full) begin
				in_instr = vecs[v].instr;
				v++;
			end
		end
		@(posedge clk);
		#1 in_push = 1'b0;
		wait (rob_count >= num_vecs && issue_count >= num_vecs);
		repeat (10) @(posedge clk);     // Room for a late duplicate to show up.
		@(negedge clk);
		if (rob_count != num_vecs) report_error("more reorder entries than vectors");
		if (issue_count != num_vecs) report_error("more issued entries than vectors");
		if (issue_valid) report_error("an entry is still waiting on the issue bus at the end");
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// Random back-pressure on the issue bus and the reorder buffer.
	initial begin
		rng = 32'h9aa0;
		wait (loaded);
		wait (!reset);
		forever begin
			@(posedge clk);
			#1;
			rng = xorshift(rng);
			issue_ready = hold | rng[0];
			rob_full = ~hold & (rng[5:4] == 2'b00);
		end
	end

	// Commits stay withheld except to free the copy that a stalled write waits on.
	initial begin
		wait (loaded);
		for (int v = 0; v < num_vecs; v++) begin
			if (prev_write[v] >= 0) begin
				wait (rob_count >= v);
				@(negedge clk);
				hold = 1'b1;
				repeat (8) @(posedge clk);
				#1;
				commit.valid = 1'b1;
				commit.tag = vecs[prev_write[v]].rd_tag;   // Oldest busy copy of that register.
				released[v] = 1'b1;
				@(posedge clk);
				#1 commit = '0;
				@(negedge clk);
				hold = 1'b0;
			end
		end
	end

	always @(negedge clk) begin
		if (!reset && rob_push) begin
			if (rob_count >= num_vecs) begin
				report_error("a reorder entry was pushed after every vector had dispatched");
			end else begin
				check("rob pc", rob_count, vecs[rob_count].instr.pc, rob_entry.pc);
				check("rob unit", rob_count, vecs[rob_count].instr.unit, rob_entry.unit);
				check("rob rd tag", rob_count, vecs[rob_count].rd_tag, rob_entry.rd);
				check("rob has_rd", rob_count, 64'(vecs[rob_count].instr.rd != 5'd0),
					64'(rob_entry.has_rd));
				if (prev_write[rob_count] >= 0 && !released[rob_count]) begin
					report_error($sformatf("vector %0d dispatched while its next copy was busy",
						rob_count));
				end
			end
			rob_count++;
		end
	end

	always @(negedge clk) begin
		int v;
		if (!reset && issue_valid && issue_ready) begin
			v = next_idx[issue_entry.unit];
			if (v < 0) begin
				report_error("an entry was issued with no vector left for its unit");
			end else begin
				check("issue queue", v, 64'd1 << vecs[v].instr.unit, 64'(dut.q_pops));
				check("issue pc", v, vecs[v].instr.pc, issue_entry.pc);
				check("issue imm", v, vecs[v].instr.imm, issue_entry.imm);
				case (vecs[v].instr.unit)   // Each unit reads the op through its own view.
					UNIT_ALU: check("issue alu op", v, vecs[v].instr.op.alu, issue_entry.op.alu);
					UNIT_BRU: check("issue bru op", v, vecs[v].instr.op.bru, issue_entry.op.bru);
					UNIT_LSU: check("issue lsu op", v, vecs[v].instr.op.lsu, issue_entry.op.lsu);
					default: check("issue mul op", v, vecs[v].instr.op.mul, issue_entry.op.mul);
				endcase
				check("issue rd tag", v, vecs[v].rd_tag, issue_entry.rd);
				check("issue rs1 tag", v, vecs[v].rs1_tag, issue_entry.rs1);
				check("issue rs2 tag", v, vecs[v].rs2_tag, issue_entry.rs2);
				next_idx[issue_entry.unit] = find_unit(issue_entry.unit, v + 1);
			end
			issue_count++;
		end
	end

	initial begin
		wait (loaded);
		repeat (RESET_CYCLES + 20 + CYCLES_PER_VEC * num_vecs) @(posedge clk);
		$display("Error: timeout with %0d of %0d entries issued and %0d dispatched",
			issue_count, num_vecs, rob_count);
		$display("Simulation failed");
		$finish;
	end

endmodule

// ==== verification/dispatch_assert.sv ====
// ##############################
// Dispatch assertions
// Queue overflow, one-hot routing
// and reset state of the top.
// ##############################

`timescale 1ns/10ps
`include "dispatch_consts.svh"

module dispatch_assert import rename_pkg::*; (
	input logic                  clk,
	input logic                  reset,
	input logic                  in_push,
	input logic                  in_full,
	input logic                  rob_push,
	input logic                  issue_valid,
	input logic                  issue_ready,
	input issue_entry_t          issue_entry,
	input logic [`NUM_UNITS-1:0] q_pops
);

	assert property (@(posedge clk) disable iff (reset) in_push |-> !in_full)
		else $error("push into a full instruction queue");

	// An issued entry comes from the one queue of its own unit class.
	assert property (@(posedge clk) disable iff (reset)
			(issue_valid && issue_ready) |-> ($onehot(q_pops) && q_pops[issue_entry.unit]))
		else $error("issued entry did not come from the queue of its unit");

	assert property (@(posedge clk) reset |=> (!in_full && !rob_push && !issue_valid))
		else $error("top level outputs not idle after reset");

endmodule

bind dispatch_top dispatch_assert u_dispatch_assert (
	.clk         (clk),
	.reset       (reset),
	.in_push     (in_push),
	.in_full     (in_full),
	.rob_push    (rob_push),
	.issue_valid (issue_valid),
	.issue_ready (issue_ready),
	.issue_entry (issue_entry),
	.q_pops      (q_pops)
);

// ==== src/dispatch_top.sv ====
// ############################
// Dispatch top
// Instruction queue, dispatch,
// issue queues and selector.
// ############################

`timescale 1ns/10ps
`include "dispatch_consts.svh"

module dispatch_top import decode_pkg::*; import rename_pkg::*; (
	input  logic           clk,
	input  logic           reset,
	input  logic           in_push,
	input  decoded_instr_t in_instr,
	output logic           in_full,
	output logic           rob_push,
	output rob_entry_t     rob_entry,
	input  logic           rob_full,
	input  commit_t        commit,
	output logic           issue_valid,
	output issue_entry_t   issue_entry,
	input  logic           issue_ready
);

	decoded_instr_t head_instr;
	logic head_valid;
	logic iq_pop;

	logic [`NUM_UNITS-1:0] q_push;
	logic [`NUM_UNITS-1:0] q_full;
	issue_entry_t q_entry;
	issue_entry_t [`NUM_UNITS-1:0] q_heads;
	logic [`NUM_UNITS-1:0] q_not_empty;
	logic [`NUM_UNITS-1:0] q_pops;

	instr_queue u_instr_queue (
		.clk        (clk),
		.reset      (reset),
		.push       (in_push),
		.instr      (in_instr),
		.full       (in_full),
		.pop        (iq_pop),
		.head       (head_instr),
		.head_valid (head_valid)
	);

	dispatch u_dispatch (
		.clk        (clk),
		.reset      (reset),
		.head       (head_instr),
		.head_valid (head_valid),
		.pop        (iq_pop),
		.q_push     (q_push),
		.q_full     (q_full),
		.q_entry    (q_entry),
		.rob_push   (rob_push),
		.rob_entry  (rob_entry),
		.rob_full   (rob_full),
		.commit     (commit)
	);

	// One queue per unit class, indexed by unit_e.
	for (genvar u = 0; u < `NUM_UNITS; u++) begin : g_issue_q
		issue_queue #(.DEPTH(`ISSUE_Q_DEPTH)) u_issue_q (
			.clk       (clk),
			.reset     (reset),
			.push      (q_push[u]),
			.entry     (q_entry),
			.full      (q_full[u]),
			.pop       (q_pops[u]),
			.head      (q_heads[u]),
			.not_empty (q_not_empty[u])
		);
	end

	issue_select u_issue_select (
		.clk         (clk),
		.reset       (reset),
		.heads       (q_heads),
		.not_empty   (q_not_empty),
		.pops        (q_pops),
		.issue_valid (issue_valid),
		.issue_entry (issue_entry),
		.issue_ready (issue_ready)
	);

endmodule

// ==== src/issue_select.sv ====
// ############################
// Issue select
// Round-robin drain of the
// issue queues onto one bus.
// ############################

`timescale 1ns/10ps
`include "dispatch_consts.svh"

module issue_select import rename_pkg::*; (
	input  logic                                clk,
	input  logic                                reset,
	input  issue_entry_t [`NUM_UNITS-1:0]       heads,
	input  logic [`NUM_UNITS-1:0]               not_empty,
	output logic [`NUM_UNITS-1:0]               pops,
	output logic                                issue_valid,
	output issue_entry_t                        issue_entry,
	input  logic                                issue_ready
);

	localparam int SEL_W = $clog2(`NUM_UNITS);

	logic [SEL_W-1:0] last_q;
	logic [SEL_W-1:0] sel;
	logic accept;

	// Scan from the farthest queue back to the next one, so the nearest wins.
	always_comb begin
		sel = last_q;
		for (int i = `NUM_UNITS; i >= 1; i--) begin
			if (not_empty[(int'(last_q) + i) % `NUM_UNITS]) begin
				sel = SEL_W'((int'(last_q) + i) % `NUM_UNITS);
			end
		end
	end

	assign issue_valid = |not_empty;
	assign issue_entry = heads[sel];
	assign accept = issue_valid & issue_ready;

	always_comb begin
		pops = '0;
		pops[sel] = accept;     // Only the granted queue pops.
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			last_q <= SEL_W'(`NUM_UNITS - 1);   // First grant goes to queue 0.
		end else if (accept) begin
			last_q <= sel;
		end
	end

endmodule

// ==== src/issue_queue.sv ====
// ############################
// Issue queue
// In-order FIFO of renamed
// entries for one unit class.
// ############################

`timescale 1ns/10ps
`include "dispatch_consts.svh"

module issue_queue import rename_pkg::*; #(
	parameter int DEPTH = `ISSUE_Q_DEPTH
) (
	input  logic         clk,
	input  logic         reset,
	input  logic         push,
	input  issue_entry_t entry,
	output logic         full,
	input  logic         pop,
	output issue_entry_t head,
	output logic         not_empty
);

	// Pointers carry one extra wrap bit, so DEPTH must be a power of two.
	localparam int AW = $clog2(DEPTH);
	localparam logic [AW:0] FULL_CNT = (AW + 1)'(DEPTH);

	issue_entry_t slots [DEPTH];
	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;
	logic [AW:0] wr_ptr_nxt;
	logic [AW:0] rd_ptr_nxt;
	logic do_push;
	logic do_pop;

	assign not_empty = (wr_ptr != rd_ptr);
	assign head = slots[rd_ptr[AW-1:0]];

	assign do_push = push & ~full;
	assign do_pop = pop & not_empty;
	assign wr_ptr_nxt = wr_ptr + {{AW{1'b0}}, do_push};
	assign rd_ptr_nxt = rd_ptr + {{AW{1'b0}}, do_pop};

	always_ff @(posedge clk) begin
		if (do_push) slots[wr_ptr[AW-1:0]] <= entry;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			full <= 1'b0;
		end else begin
			wr_ptr <= wr_ptr_nxt;
			rd_ptr <= rd_ptr_nxt;
			full <= ((wr_ptr_nxt - rd_ptr_nxt) == FULL_CNT);   // Registered level.
		end
	end

endmodule

// ==== src/dispatch.sv ====
// ############################
// Dispatch
// Renames the queue head and
// sends it to one issue queue
// and to the reorder buffer.
// ############################

`timescale 1ns/10ps
`include "dispatch_consts.svh"

module dispatch import decode_pkg::*; import rename_pkg::*; (
	input  logic                  clk,
	input  logic                  reset,
	input  decoded_instr_t        head,
	input  logic                  head_valid,
	output logic                  pop,
	output logic [`NUM_UNITS-1:0] q_push,
	input  logic [`NUM_UNITS-1:0] q_full,
	output issue_entry_t          q_entry,
	output logic                  rob_push,
	output rob_entry_t            rob_entry,
	input  logic                  rob_full,
	input  commit_t               commit
);

	reg_tag_t rs1_tag;
	reg_tag_t rs2_tag;
	reg_tag_t rd_tag;
	logic run_out;
	logic fire;

	rename_table u_rename (
		.clk     (clk),
		.reset   (reset),
		.rs1     (head.rs1),
		.rs2     (head.rs2),
		.rd      (head.rd),
		.alloc   (fire),
		.rs1_tag (rs1_tag),
		.rs2_tag (rs2_tag),
		.rd_tag  (rd_tag),
		.run_out (run_out),
		.commit  (commit)
	);

	// Every resource is checked at once so the three strobes move together.
	assign fire = head_valid & ~q_full[head.unit] & ~rob_full & ~run_out;
	assign pop = fire;
	assign rob_push = fire;

	always_comb begin
		q_push = '0;
		q_push[head.unit] = fire;   // The unit class picks the queue.
	end

	always_comb begin
		q_entry.unit = head.unit;
		q_entry.op = head.op;
		q_entry.pc = head.pc;
		q_entry.imm = head.imm;
		q_entry.rd = rd_tag;
		q_entry.rs1 = rs1_tag;
		q_entry.rs2 = rs2_tag;
	end

	always_comb begin
		rob_entry.pc = head.pc;
		rob_entry.unit = head.unit;
		rob_entry.rd = rd_tag;
		rob_entry.has_rd = (head.rd != 5'd0);
	end

endmodule

// ==== src/rename_table.sv ====
// ############################
// Rename table
// Current copy and busy bits for
// each architectural register.
// ############################

`timescale 1ns/10ps
`include "dispatch_consts.svh"

module rename_table import rename_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic [4:0] rs1,
	input  logic [4:0] rs2,
	input  logic [4:0] rd,
	input  logic       alloc,
	output reg_tag_t   rs1_tag,
	output reg_tag_t   rs2_tag,
	output reg_tag_t   rd_tag,
	output logic       run_out,
	input  commit_t    commit
);

	localparam int COPY_W = $clog2(`RENAME_COPIES);
	localparam logic [COPY_W-1:0] LAST_COPY = COPY_W'(`RENAME_COPIES - 1);

	logic [COPY_W-1:0] cur_copy [32];
	logic [`RENAME_COPIES-1:0] busy [32];
	logic [COPY_W-1:0] next_copy;
	logic rd_is_x0;

	assign rd_is_x0 = (rd == 5'd0);

	always_comb begin
		// Copies are handed out in a fixed rotation.
		next_copy = (cur_copy[rd] == LAST_COPY) ? '0 : cur_copy[rd] + 1'b1;

		// Sources see the table before this instruction's own rd is applied.
		rs1_tag.arch = rs1;
		rs1_tag.copy = (rs1 == 5'd0) ? '0 : cur_copy[rs1];
		rs2_tag.arch = rs2;
		rs2_tag.copy = (rs2 == 5'd0) ? '0 : cur_copy[rs2];

		rd_tag.arch = rd;
		rd_tag.copy = rd_is_x0 ? '0 : next_copy;

		// x0 is hardwired and can never run out of copies.
		run_out = ~rd_is_x0 & busy[rd][next_copy];
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int r = 0; r < 32; r++) begin
				cur_copy[r] <= '0;
				busy[r] <= '0;
			end
		end else begin
			if (commit.valid && commit.tag.arch != 5'd0) begin
				busy[commit.tag.arch][commit.tag.copy] <= 1'b0;   // Copy retired.
			end
			// Allocation comes last so it wins over a commit to the same bit.
			if (alloc && !rd_is_x0 && !run_out) begin
				cur_copy[rd] <= next_copy;
				busy[rd][next_copy] <= 1'b1;
			end
		end
	end

endmodule

// ==== src/instr_queue.sv ====
// ############################
// Instruction queue
// Circular buffer of decoded
// instructions ahead of dispatch.
// ############################

`timescale 1ns/10ps
`include "dispatch_consts.svh"

module instr_queue import decode_pkg::*; (
	input  logic           clk,
	input  logic           reset,
	input  logic           push,
	input  decoded_instr_t instr,
	output logic           full,
	input  logic           pop,
	output decoded_instr_t head,
	output logic           head_valid
);

	localparam int PTR_W = $clog2(`DISPATCH_IQ_DEPTH);
	localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(`DISPATCH_IQ_DEPTH - 1);
	localparam logic [PTR_W:0] DEPTH_CNT = (PTR_W + 1)'(`DISPATCH_IQ_DEPTH);

	decoded_instr_t mem [`DISPATCH_IQ_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0] count;
	logic do_push;
	logic do_pop;

	assign full = (count == DEPTH_CNT);
	assign head_valid = (count != '0);
	assign head = mem[rd_ptr];

	assign do_push = push & ~full;      // A push into a full queue is lost.
	assign do_pop = pop & head_valid;

	always_ff @(posedge clk) begin
		if (do_push) mem[wr_ptr] <= instr;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
			if (do_pop) rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
			// Simultaneous push and pop leave the count alone.
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// ==== src/rename_pkg.sv ====
// ############################
// Rename types
// Register tags and the entries
// that leave dispatch.
// ############################

`include "dispatch_consts.svh"

package rename_pkg;
	import decode_pkg::*;

	// Architectural register plus the copy that holds its value.
	typedef struct packed {
		logic [4:0]                       arch;
		logic [$clog2(`RENAME_COPIES)-1:0] copy;
	} reg_tag_t;

	typedef struct packed {
		unit_e       unit;
		op_u         op;
		logic [63:0] pc;
		logic [63:0] imm;
		reg_tag_t    rd;
		reg_tag_t    rs1;
		reg_tag_t    rs2;
	} issue_entry_t;

	typedef struct packed {
		logic [63:0] pc;
		unit_e       unit;
		reg_tag_t    rd;
		logic        has_rd;  // Low when rd is x0.
	} rob_entry_t;

	// One-cycle strobe that frees a register copy.
	typedef struct packed {
		logic     valid;
		reg_tag_t tag;
	} commit_t;

endpackage

// ==== src/decode_pkg.sv ====
// ############################
// Decode types
// Unit classes, operation codes
// and the decoded instruction.
// ############################

package decode_pkg;

	// Which execution unit the instruction goes to.
	typedef enum logic [1:0] {
		UNIT_ALU = 2'd0,
		UNIT_BRU = 2'd1,
		UNIT_LSU = 2'd2,
		UNIT_MUL = 2'd3
	} unit_e;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA,
		ALU_SLT, ALU_SLTU, ALU_LUI, ALU_AUIPC, ALU_ADDW, ALU_SUBW
	} alu_op_e;

	typedef enum logic [3:0] {
		BRU_JAL, BRU_JALR, BRU_BEQ, BRU_BNE, BRU_BLT, BRU_BGE, BRU_BLTU, BRU_BGEU
	} bru_op_e;

	typedef enum logic [3:0] {
		LSU_LB, LSU_LH, LSU_LW, LSU_LD, LSU_LBU, LSU_LHU, LSU_LWU,
		LSU_SB, LSU_SH, LSU_SW, LSU_SD, LSU_FENCE, LSU_FENCE_I
	} lsu_op_e;

	typedef enum logic [3:0] {
		MUL_MUL, MUL_MULH, MUL_MULHSU, MUL_MULHU, MUL_DIV, MUL_DIVU, MUL_REM, MUL_REMU,
		MUL_MULW, MUL_DIVW, MUL_DIVUW, MUL_REMW, MUL_REMUW
	} mul_op_e;

	// The unit field of the same instruction selects the view.
	typedef union packed {
		alu_op_e alu;
		bru_op_e bru;
		lsu_op_e lsu;
		mul_op_e mul;
	} op_u;

	typedef struct packed {
		unit_e       unit;
		op_u         op;
		logic [63:0] pc;
		logic [63:0] imm;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
	} decoded_instr_t;

endpackage

// ==== src/dispatch_consts.svh ====
// ############################
// Dispatch constants
// Sizes shared by the dispatch
// stage and its queues.
// ############################

`ifndef DISPATCH_CONSTS_SVH
`define DISPATCH_CONSTS_SVH

// Depth of the decoded instruction queue.
`define DISPATCH_IQ_DEPTH 8

`define ISSUE_Q_DEPTH 4     // Entries in each issue queue.

`define RENAME_COPIES 4     // Physical copies per architectural register.

`define NUM_UNITS 4         // One issue queue per unit class.

`endif
